// ==== include/qdrc_config.svh ====
`ifndef QDRC_CONFIG_SVH
`define QDRC_CONFIG_SVH

// data word width for each of the rise and fall halves of a burst
`define QDRC_DATA_WIDTH 36
`define QDRC_BW_WIDTH 4            // one active-low byte-write lane per 9 data bits
`define QDRC_ADDR_WIDTH 21

// read command at the pin register input to nominal data at the q inputs
`define QDRC_READ_LATENCY 9
`define QDRC_SETTLE_CYCLES 16      // memory settle time after reset

`endif

// ==== hdl/qdrc_pkg.sv ====
`include "qdrc_config.svh"

package qdrc_pkg;

  // one single-rate half of a burst, either rise or fall
  typedef logic [`QDRC_DATA_WIDTH-1:0] qdr_data_t;

  // byte-write enables, a low bit writes its 9-bit lane
  typedef logic [`QDRC_BW_WIDTH-1:0] qdr_bw_t;

  typedef logic [`QDRC_ADDR_WIDTH-1:0] qdr_addr_t; // burst address

endpackage

// ==== hdl/qdrc_phy_sequencer.sv ====
`timescale 1ns/100ps
`include "qdrc_config.svh"

module qdrc_phy_sequencer (
  input  logic clk,
  input  logic reset,
  input  logic burst_align_done,
  input  logic burst_align_fail,
  output logic burst_align_start,
  output logic cal_done,
  output logic cal_fail,
  output logic user_ready
);

  localparam int CNT_W = $clog2(`QDRC_SETTLE_CYCLES + 1);
  localparam logic [CNT_W-1:0] SETTLE_LAST = CNT_W'(`QDRC_SETTLE_CYCLES - 1);
  localparam logic [CNT_W-1:0] SETTLE_END  = CNT_W'(`QDRC_SETTLE_CYCLES);

  logic [CNT_W-1:0] settle_cnt;

  // the counter parks at its end value so the start pulse fires only once
  always_ff @(posedge clk) begin
    if (reset) begin
      settle_cnt <= '0;
    end else if (settle_cnt != SETTLE_END) begin
      settle_cnt <= settle_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      burst_align_start <= 1'b0;
    end else begin
      burst_align_start <= (settle_cnt == SETTLE_LAST);
    end
  end

  // status levels from the alignment block are sticky already
  always_ff @(posedge clk) begin
    if (reset) begin
      cal_done <= 1'b0;
      cal_fail <= 1'b0;
    end else begin
      cal_done <= burst_align_done;
      cal_fail <= burst_align_fail;
    end
  end

  // a failed calibration keeps the user path closed
  assign user_ready = cal_done & ~cal_fail;

endmodule

// ==== hdl/qdrc_phy_burst_align.sv ====
`timescale 1ns/100ps
`include "qdrc_config.svh"

module qdrc_phy_burst_align (
  input  logic                clk,
  input  logic                reset,
  input  logic                burst_align_start,
  input  qdrc_pkg::qdr_data_t qdr_q_rise,
  input  qdrc_pkg::qdr_data_t qdr_q_fall,
  output logic                burst_align_done,
  output logic                burst_align_fail,
  output qdrc_pkg::qdr_data_t cal_d_rise,
  output qdrc_pkg::qdr_data_t cal_d_fall,
  output qdrc_pkg::qdr_bw_t   cal_bw_n_rise,
  output qdrc_pkg::qdr_bw_t   cal_bw_n_fall,
  output logic                cal_w_n,
  output logic                cal_r_n,
  output qdrc_pkg::qdr_addr_t cal_sa,
  output qdrc_pkg::qdr_data_t q_rise_cal,
  output qdrc_pkg::qdr_data_t q_fall_cal
);

  // bit 0 is the write command, bit 1 the write data and read command,
  // then the read latency runs out to the two sample points
  localparam int SAMPLE_IDX = `QDRC_READ_LATENCY + 1;
  localparam int CHECK_IDX  = SAMPLE_IDX + 1;

  logic [CHECK_IDX:0]  burst_state;
  qdrc_pkg::qdr_data_t offset;      // high selects the direct copy of a bit
  qdrc_pkg::qdr_data_t q_rise_z;
  qdrc_pkg::qdr_data_t q_fall_z;
  logic                done_reg;
  logic                fail_reg;

  always_ff @(posedge clk) begin
    if (reset) begin
      burst_state <= '0;
    end else begin
      burst_state <= {burst_state[CHECK_IDX-1:0], burst_align_start};
    end
  end

  // training burst to address zero, rise word all zeros and fall word all ones
  assign cal_w_n       = ~burst_state[0];
  assign cal_r_n       = ~burst_state[1];
  assign cal_sa        = '0;
  assign cal_d_rise    = '0;
  assign cal_d_fall    = burst_state[1] ? '1 : '0;
  assign cal_bw_n_rise = burst_state[1] ? '0 : '1;  // all lanes enabled for the data beat
  assign cal_bw_n_fall = burst_state[1] ? '0 : '1;

  always_ff @(posedge clk) begin
    q_rise_z <= qdr_q_rise;
    q_fall_z <= qdr_q_fall;
  end

  // late bits come straight from the pins, on-time bits take the extra register
  assign q_rise_cal = (offset & qdr_q_rise) | (~offset & q_rise_z);
  assign q_fall_cal = (offset & qdr_q_fall) | (~offset & q_fall_z);

  always_ff @(posedge clk) begin
    if (reset) begin
      offset <= '1;
    end else if (burst_state[SAMPLE_IDX]) begin
      offset <= ~qdr_q_fall;          // a low fall bit at the nominal point has not arrived yet
    end
  end

  // one cycle after the nominal sample every late bit must show the ones pattern
  always_ff @(posedge clk) begin
    if (reset) begin
      done_reg <= 1'b0;
      fail_reg <= 1'b0;
    end else if (burst_state[CHECK_IDX]) begin
      done_reg <= 1'b1;
      fail_reg <= fail_reg | (|(offset & ~qdr_q_fall));
    end
  end

  assign burst_align_done = done_reg;
  assign burst_align_fail = fail_reg;

endmodule

// ==== hdl/qdrc_phy_bus_mux.sv ====
`timescale 1ns/100ps
`include "qdrc_config.svh"

module qdrc_phy_bus_mux (
  input  logic                clk,
  input  logic                reset,
  input  logic                user_sel,
  input  qdrc_pkg::qdr_data_t cal_d_rise,
  input  qdrc_pkg::qdr_data_t cal_d_fall,
  input  qdrc_pkg::qdr_bw_t   cal_bw_n_rise,
  input  qdrc_pkg::qdr_bw_t   cal_bw_n_fall,
  input  logic                cal_w_n,
  input  logic                cal_r_n,
  input  qdrc_pkg::qdr_addr_t cal_sa,
  input  logic                user_w_req,
  input  logic                user_r_req,
  input  qdrc_pkg::qdr_addr_t user_addr,
  input  qdrc_pkg::qdr_data_t user_wdata_rise,
  input  qdrc_pkg::qdr_data_t user_wdata_fall,
  input  qdrc_pkg::qdr_bw_t   user_bw_n_rise,
  input  qdrc_pkg::qdr_bw_t   user_bw_n_fall,
  output qdrc_pkg::qdr_data_t qdr_d_rise,
  output qdrc_pkg::qdr_data_t qdr_d_fall,
  output qdrc_pkg::qdr_bw_t   qdr_bw_n_rise,
  output qdrc_pkg::qdr_bw_t   qdr_bw_n_fall,
  output logic                qdr_w_n,
  output logic                qdr_r_n,
  output qdrc_pkg::qdr_addr_t qdr_sa,
  output logic                user_rvalid
);

  localparam int LAT = `QDRC_READ_LATENCY;

  logic                w_req_d;         // write data beat follows its command by one cycle
  qdrc_pkg::qdr_data_t wdata_rise_d;
  qdrc_pkg::qdr_data_t wdata_fall_d;
  qdrc_pkg::qdr_bw_t   bw_n_rise_d;
  qdrc_pkg::qdr_bw_t   bw_n_fall_d;
  logic [LAT:0]        rvalid_sr;

  always_ff @(posedge clk) begin
    if (reset) begin
      w_req_d <= 1'b0;
    end else begin
      w_req_d <= user_sel & user_w_req;
    end
  end

  always_ff @(posedge clk) begin
    wdata_rise_d <= user_wdata_rise;
    wdata_fall_d <= user_wdata_fall;
    bw_n_rise_d  <= user_bw_n_rise;
    bw_n_fall_d  <= user_bw_n_fall;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      qdr_w_n       <= 1'b1;
      qdr_r_n       <= 1'b1;
      qdr_bw_n_rise <= '1;
      qdr_bw_n_fall <= '1;
    end else if (user_sel) begin
      qdr_w_n       <= ~user_w_req;
      qdr_r_n       <= ~user_r_req;
      qdr_bw_n_rise <= w_req_d ? bw_n_rise_d : '1;   // lanes stay masked without a data beat
      qdr_bw_n_fall <= w_req_d ? bw_n_fall_d : '1;
    end else begin
      qdr_w_n       <= cal_w_n;
      qdr_r_n       <= cal_r_n;
      qdr_bw_n_rise <= cal_bw_n_rise;
      qdr_bw_n_fall <= cal_bw_n_fall;
    end
  end

  always_ff @(posedge clk) begin
    qdr_d_rise <= user_sel ? wdata_rise_d : cal_d_rise;
    qdr_d_fall <= user_sel ? wdata_fall_d : cal_d_fall;
    qdr_sa     <= user_sel ? user_addr : cal_sa;
  end

  // one stage per cycle of read latency plus the re-timing register
  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid_sr <= '0;
    end else begin
      rvalid_sr <= {rvalid_sr[LAT-1:0], user_sel & user_r_req};
    end
  end

  assign user_rvalid = rvalid_sr[LAT];

endmodule

// ==== hdl/qdrc_phy.sv ====
`timescale 1ns/100ps

module qdrc_phy (
  input  logic                clk,
  input  logic                reset,
  input  logic                user_w_req,
  input  logic                user_r_req,
  input  qdrc_pkg::qdr_addr_t user_addr,
  input  qdrc_pkg::qdr_data_t user_wdata_rise,
  input  qdrc_pkg::qdr_data_t user_wdata_fall,
  input  qdrc_pkg::qdr_bw_t   user_bw_n_rise,
  input  qdrc_pkg::qdr_bw_t   user_bw_n_fall,
  output logic                cal_done,
  output logic                cal_fail,
  output logic                user_ready,
  output logic                user_rvalid,
  output qdrc_pkg::qdr_data_t user_rdata_rise,
  output qdrc_pkg::qdr_data_t user_rdata_fall,
  output qdrc_pkg::qdr_data_t qdr_d_rise,
  output qdrc_pkg::qdr_data_t qdr_d_fall,
  input  qdrc_pkg::qdr_data_t qdr_q_rise,
  input  qdrc_pkg::qdr_data_t qdr_q_fall,
  output qdrc_pkg::qdr_bw_t   qdr_bw_n_rise,
  output qdrc_pkg::qdr_bw_t   qdr_bw_n_fall,
  output logic                qdr_w_n,
  output logic                qdr_r_n,
  output qdrc_pkg::qdr_addr_t qdr_sa
);

  logic                burst_align_start;
  logic                burst_align_done;
  logic                burst_align_fail;
  qdrc_pkg::qdr_data_t cal_d_rise;
  qdrc_pkg::qdr_data_t cal_d_fall;
  qdrc_pkg::qdr_bw_t   cal_bw_n_rise;
  qdrc_pkg::qdr_bw_t   cal_bw_n_fall;
  logic                cal_w_n;
  logic                cal_r_n;
  qdrc_pkg::qdr_addr_t cal_sa;

  qdrc_phy_sequencer sequencer_i (
    .clk               (clk),
    .reset             (reset),
    .burst_align_done  (burst_align_done),
    .burst_align_fail  (burst_align_fail),
    .burst_align_start (burst_align_start),
    .cal_done          (cal_done),
    .cal_fail          (cal_fail),
    .user_ready        (user_ready)
  );

  // read data passes through the alignment block for per-bit re-timing
  qdrc_phy_burst_align burst_align_i (
    .clk               (clk),
    .reset             (reset),
    .burst_align_start (burst_align_start),
    .qdr_q_rise        (qdr_q_rise),
    .qdr_q_fall        (qdr_q_fall),
    .burst_align_done  (burst_align_done),
    .burst_align_fail  (burst_align_fail),
    .cal_d_rise        (cal_d_rise),
    .cal_d_fall        (cal_d_fall),
    .cal_bw_n_rise     (cal_bw_n_rise),
    .cal_bw_n_fall     (cal_bw_n_fall),
    .cal_w_n           (cal_w_n),
    .cal_r_n           (cal_r_n),
    .cal_sa            (cal_sa),
    .q_rise_cal        (user_rdata_rise),
    .q_fall_cal        (user_rdata_fall)
  );

  qdrc_phy_bus_mux bus_mux_i (
    .clk             (clk),
    .reset           (reset),
    .user_sel        (user_ready),   // pins go to the user once calibration is clean
    .cal_d_rise      (cal_d_rise),
    .cal_d_fall      (cal_d_fall),
    .cal_bw_n_rise   (cal_bw_n_rise),
    .cal_bw_n_fall   (cal_bw_n_fall),
    .cal_w_n         (cal_w_n),
    .cal_r_n         (cal_r_n),
    .cal_sa          (cal_sa),
    .user_w_req      (user_w_req),
    .user_r_req      (user_r_req),
    .user_addr       (user_addr),
    .user_wdata_rise (user_wdata_rise),
    .user_wdata_fall (user_wdata_fall),
    .user_bw_n_rise  (user_bw_n_rise),
    .user_bw_n_fall  (user_bw_n_fall),
    .qdr_d_rise      (qdr_d_rise),
    .qdr_d_fall      (qdr_d_fall),
    .qdr_bw_n_rise   (qdr_bw_n_rise),
    .qdr_bw_n_fall   (qdr_bw_n_fall),
    .qdr_w_n         (qdr_w_n),
    .qdr_r_n         (qdr_r_n),
    .qdr_sa          (qdr_sa),
    .user_rvalid     (user_rvalid)
  );

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
  input  logic reset_req,
  output logic clk,
  output logic reset
);

  localparam int RESET_CYCLES = 8;

  int rst_cnt = RESET_CYCLES - 1;   // the first cycle is covered by the initial value

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
  end

  always #10 clk = ~clk;

  // a request seen on a rising edge restarts the reset window
  always @(posedge clk) begin
    if (reset_req) begin
      rst_cnt = RESET_CYCLES;
    end
  end

  // reset changes on the falling edge like every other DUT input
  always @(negedge clk) begin
    if (rst_cnt > 0) begin
      reset <= 1'b1;
      rst_cnt = rst_cnt - 1;
    end else begin
      reset <= 1'b0;
    end
  end

endmodule

// ==== dv/qdr_sram_model.sv ====
`timescale 1ns/100ps
`include "qdrc_config.svh"

module qdr_sram_model (
  input  logic                clk,
  input  qdrc_pkg::qdr_data_t d_rise,
  input  qdrc_pkg::qdr_data_t d_fall,
  input  qdrc_pkg::qdr_bw_t   bw_n_rise,
  input  qdrc_pkg::qdr_bw_t   bw_n_fall,
  input  logic                w_n,
  input  logic                r_n,
  input  qdrc_pkg::qdr_addr_t sa,
  input  qdrc_pkg::qdr_data_t skew_mask,    // set bits return one cycle late
  input  qdrc_pkg::qdr_data_t stuck_mask,   // set bits always read low
  output qdrc_pkg::qdr_data_t q_rise,
  output qdrc_pkg::qdr_data_t q_fall
);

  localparam int LAT = `QDRC_READ_LATENCY;

  qdrc_pkg::qdr_data_t mem_rise [qdrc_pkg::qdr_addr_t];
  qdrc_pkg::qdr_data_t mem_fall [qdrc_pkg::qdr_addr_t];
  qdrc_pkg::qdr_data_t pipe_rise [0:LAT-1];
  qdrc_pkg::qdr_data_t pipe_fall [0:LAT-1];
  logic                w_pend = 1'b0;     // data beat follows the write command
  qdrc_pkg::qdr_addr_t w_addr;

  function automatic qdrc_pkg::qdr_data_t merge_lanes(input qdrc_pkg::qdr_data_t old_word,
                                                       input qdrc_pkg::qdr_data_t new_word,
                                                       input qdrc_pkg::qdr_bw_t bw_n);
    qdrc_pkg::qdr_data_t word;
    word = old_word;
    for (int i = 0; i < `QDRC_BW_WIDTH; i++) begin
      if (!bw_n[i]) begin
        word[9*i +: 9] = new_word[9*i +: 9];
      end
    end
    return word;
  endfunction

  initial begin
    for (int i = 0; i < LAT; i++) begin
      pipe_rise[i] = '0;
      pipe_fall[i] = '0;
    end
  end

  // the pending write lands before a read at the same edge sees the array
  always @(posedge clk) begin
    if (w_pend) begin
      mem_rise[w_addr] = merge_lanes(mem_rise.exists(w_addr) ? mem_rise[w_addr] : '0,
                                     d_rise, bw_n_rise);
      mem_fall[w_addr] = merge_lanes(mem_fall.exists(w_addr) ? mem_fall[w_addr] : '0,
                                     d_fall, bw_n_fall);
    end
    w_pend = (w_n === 1'b0);
    w_addr = sa;
    for (int i = LAT - 1; i > 0; i--) begin
      pipe_rise[i] <= pipe_rise[i-1];
      pipe_fall[i] <= pipe_fall[i-1];
    end
    if (r_n === 1'b0 && mem_rise.exists(sa)) begin
      pipe_rise[0] <= mem_rise[sa];
      pipe_fall[0] <= mem_fall[sa];
    end else begin
      pipe_rise[0] <= '0;             // the bus reads low between bursts
      pipe_fall[0] <= '0;
    end
  end

  // nominal bits arrive read latency minus one cycles after the pins, skewed bits one later
  assign q_rise = ((pipe_rise[LAT-2] & ~skew_mask) | (pipe_rise[LAT-1] & skew_mask))
                  & ~stuck_mask;
  assign q_fall = ((pipe_fall[LAT-2] & ~skew_mask) | (pipe_fall[LAT-1] & skew_mask))
                  & ~stuck_mask;

endmodule

// ==== dv/tb_qdrc_phy.sv ====
`timescale 1ns/100ps
`include "qdrc_config.svh"

module tb_qdrc_phy;

  localparam int LAT        = `QDRC_READ_LATENCY;
  localparam int SEED       = 96267;
  localparam int WAIT_LIMIT = 200;
  localparam int NUM_WORDS  = 8;

  logic                clk;
  logic                reset;
  logic                reset_req;
  logic                user_w_req;
  logic                user_r_req;
  qdrc_pkg::qdr_addr_t user_addr;
  qdrc_pkg::qdr_data_t user_wdata_rise;
  qdrc_pkg::qdr_data_t user_wdata_fall;
  qdrc_pkg::qdr_bw_t   user_bw_n_rise;
  qdrc_pkg::qdr_bw_t   user_bw_n_fall;
  logic                cal_done;
  logic                cal_fail;
  logic                user_ready;
  logic                user_rvalid;
  qdrc_pkg::qdr_data_t user_rdata_rise;
  qdrc_pkg::qdr_data_t user_rdata_fall;
  qdrc_pkg::qdr_data_t qdr_d_rise;
  qdrc_pkg::qdr_data_t qdr_d_fall;
  qdrc_pkg::qdr_data_t qdr_q_rise;
  qdrc_pkg::qdr_data_t qdr_q_fall;
  qdrc_pkg::qdr_bw_t   qdr_bw_n_rise;
  qdrc_pkg::qdr_bw_t   qdr_bw_n_fall;
  logic                qdr_w_n;
  logic                qdr_r_n;
  qdrc_pkg::qdr_addr_t qdr_sa;
  qdrc_pkg::qdr_data_t skew_mask;
  qdrc_pkg::qdr_data_t stuck_mask;

  qdrc_pkg::qdr_data_t sb_rise [qdrc_pkg::qdr_addr_t];    // scoreboard copy of memory
  qdrc_pkg::qdr_data_t sb_fall [qdrc_pkg::qdr_addr_t];
  qdrc_pkg::qdr_addr_t addrs [NUM_WORDS];
  int                  rd_cyc_q [$];
  qdrc_pkg::qdr_data_t rd_rise_q [$];
  qdrc_pkg::qdr_data_t rd_fall_q [$];
  qdrc_pkg::qdr_data_t chk_rise;
  qdrc_pkg::qdr_data_t chk_fall;
  logic                data_beat = 1'b0;
  int                  cyc = 0;
  int                  cal_wr_cnt = 0;
  int                  cal_rd_cnt = 0;

  tb_clock_gen clock_gen_i (.reset_req(reset_req), .clk(clk), .reset(reset));

  qdrc_phy dut_i (.*);

  qdr_sram_model sram_i (
    .clk        (clk),
    .d_rise     (qdr_d_rise),
    .d_fall     (qdr_d_fall),
    .bw_n_rise  (qdr_bw_n_rise),
    .bw_n_fall  (qdr_bw_n_fall),
    .w_n        (qdr_w_n),
    .r_n        (qdr_r_n),
    .sa         (qdr_sa),
    .skew_mask  (skew_mask),
    .stuck_mask (stuck_mask),
    .q_rise     (qdr_q_rise),
    .q_fall     (qdr_q_fall)
  );

  task automatic stop_run();
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic fail_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act);
    stop_run();
  endtask

  task automatic fail_text(input string msg);
    $display("[ERROR] %0t %s", $time, msg);
    stop_run();
  endtask

  function automatic qdrc_pkg::qdr_data_t random_word();
    return qdrc_pkg::qdr_data_t'({$urandom, $urandom});
  endfunction

  // a low enable bit replaces its 9-bit lane with the new data
  function automatic qdrc_pkg::qdr_data_t apply_byte_enables(input qdrc_pkg::qdr_data_t old_word,
                                                              input qdrc_pkg::qdr_data_t new_word,
                                                              input qdrc_pkg::qdr_bw_t bw_n);
    qdrc_pkg::qdr_data_t word;
    word = old_word;
    for (int i = 0; i < `QDRC_BW_WIDTH; i++) begin
      if (!bw_n[i]) begin
        word[9*i +: 9] = new_word[9*i +: 9];
      end
    end
    return word;
  endfunction

  assert property (@(posedge clk) reset |=> (qdr_w_n && qdr_r_n && !cal_done && !user_rvalid))
    else fail_text("pins or status not idle after a reset cycle");
  assert property (@(posedge clk) disable iff (reset) cal_fail |-> (cal_done && !user_ready))
    else fail_text("user path open after a failed calibration");

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (reset) begin
      rd_cyc_q.delete();
      rd_rise_q.delete();
      rd_fall_q.delete();
      data_beat  = 1'b0;
      cal_wr_cnt = 0;
      cal_rd_cnt = 0;
    end else begin
      // re-timed read data is valid in the same cycle as its strobe
      if (user_rvalid) begin
        assert (rd_cyc_q.size() > 0) else fail_text("user_rvalid with no read outstanding");
        assert (cyc - rd_cyc_q[0] == LAT + 1)
          else fail_value("user_rvalid delay", LAT + 1, cyc - rd_cyc_q[0]);
        void'(rd_cyc_q.pop_front());
        chk_rise = rd_rise_q.pop_front();
        chk_fall = rd_fall_q.pop_front();
        assert (user_rdata_rise == chk_rise)
          else fail_value("user_rdata_rise", chk_rise, user_rdata_rise);
        assert (user_rdata_fall == chk_fall)
          else fail_value("user_rdata_fall", chk_fall, user_rdata_fall);
      end
      if (!cal_done) begin
        if (data_beat) begin
          assert (qdr_d_fall == '1) else fail_value("qdr_d_fall", 64'hf_ffff_ffff, qdr_d_fall);
          assert (qdr_d_rise == '0) else fail_value("qdr_d_rise", 0, qdr_d_rise);
        end
        data_beat = !qdr_w_n;
        if (!qdr_w_n || !qdr_r_n) begin
          assert (qdr_sa == '0) else fail_value("qdr_sa", 0, qdr_sa);
        end
        cal_wr_cnt = cal_wr_cnt + int'(!qdr_w_n);
        cal_rd_cnt = cal_rd_cnt + int'(!qdr_r_n);
      end
      if (user_r_req && user_ready) begin
        rd_cyc_q.push_back(cyc);
        rd_rise_q.push_back(sb_rise[user_addr]);
        rd_fall_q.push_back(sb_fall[user_addr]);
      end
    end
  end

  task automatic check_idle_until_cal();
    int n;
    n = 0;
    @(posedge clk);
    do begin
      @(negedge clk);
      assert (qdr_r_n && &qdr_bw_n_rise && &qdr_bw_n_fall)
        else fail_text("pins active before calibration");
      assert ({cal_done, cal_fail, user_ready, user_rvalid} == 4'b0000)
        else fail_value("{cal_done,cal_fail,user_ready,user_rvalid}", 0,
                        {cal_done, cal_fail, user_ready, user_rvalid});
      n++;
      if (n > WAIT_LIMIT) fail_text("timeout waiting for the calibration write");
    end while (qdr_w_n);
  endtask

  task automatic wait_cal_done();
    int n;
    n = 0;
    while (!cal_done) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) fail_text("timeout waiting for cal_done");
    end
    assert (cal_wr_cnt == 1) else fail_value("calibration writes", 1, cal_wr_cnt);
    assert (cal_rd_cnt == 1) else fail_value("calibration reads", 1, cal_rd_cnt);
  endtask

  task automatic write_word(input qdrc_pkg::qdr_addr_t a, input qdrc_pkg::qdr_data_t rise,
                            input qdrc_pkg::qdr_data_t fall, input qdrc_pkg::qdr_bw_t bwr,
                            input qdrc_pkg::qdr_bw_t bwf);
    @(negedge clk);
    user_w_req      = 1'b1;
    user_addr       = a;
    user_wdata_rise = rise;
    user_wdata_fall = fall;
    user_bw_n_rise  = bwr;
    user_bw_n_fall  = bwf;
    sb_rise[a] = apply_byte_enables(sb_rise.exists(a) ? sb_rise[a] : '0, rise, bwr);
    sb_fall[a] = apply_byte_enables(sb_fall.exists(a) ? sb_fall[a] : '0, fall, bwf);
    @(negedge clk);
    user_w_req = 1'b0;
  endtask

  // strobes on consecutive cycles when count is above one
  task automatic read_burst(input int first, input int count);
    for (int i = first; i < first + count; i++) begin
      @(negedge clk);
      user_r_req = 1'b1;
      user_addr  = addrs[i];
    end
    @(negedge clk);
    user_r_req = 1'b0;
  endtask

  task automatic drain_reads();
    int n;
    n = 0;
    while (rd_cyc_q.size() != 0) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) fail_text("timeout waiting for outstanding reads");
    end
  endtask

  initial begin
    reset_req       = 1'b0;
    user_w_req      = 1'b0;
    user_r_req      = 1'b0;
    user_addr       = '0;
    user_wdata_rise = '0;
    user_wdata_fall = '0;
    user_bw_n_rise  = '1;
    user_bw_n_fall  = '1;
    stuck_mask      = '0;
    void'($urandom(SEED));
    skew_mask = random_word();
    check_idle_until_cal();
    wait_cal_done();
    assert ({cal_fail, user_ready} == 2'b01)
      else fail_value("{cal_fail,user_ready}", 1, {cal_fail, user_ready});
    for (int i = 0; i < NUM_WORDS; i++) begin
      addrs[i] = qdrc_pkg::qdr_addr_t'($urandom);
      write_word(addrs[i], random_word(), random_word(), '0, '0);
    end
    for (int i = 0; i < NUM_WORDS; i++) begin
      read_burst(i, 1);
    end
    drain_reads();
    read_burst(0, NUM_WORDS);
    drain_reads();
    write_word(addrs[2], random_word(), random_word(), 4'b1010, 4'b0101);
    read_burst(2, 1);
    drain_reads();
    stuck_mask = qdrc_pkg::qdr_data_t'(1) << ($urandom % `QDRC_DATA_WIDTH);
    @(negedge clk);
    reset_req = 1'b1;
    @(negedge clk);
    reset_req = 1'b0;
    check_idle_until_cal();
    wait_cal_done();
    assert (cal_fail) else fail_value("cal_fail", 1, cal_fail);
    repeat (40) begin
      @(negedge clk);
      assert (!user_ready) else fail_value("user_ready", 0, user_ready);
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== qdrc.f ====
+incdir+include
hdl/qdrc_pkg.sv
hdl/qdrc_phy_sequencer.sv
hdl/qdrc_phy_burst_align.sv
hdl/qdrc_phy_bus_mux.sv
hdl/qdrc_phy.sv
dv/tb_clock_gen.sv
dv/qdr_sram_model.sv
dv/tb_qdrc_phy.sv
